// ==== all.f ====
hw/sram_geom_pkg.sv
hw/stream_credit_pkg.sv
hw/sram_bank_if.sv
hw/sram_slice.sv
hw/bank_write_ctrl.sv
hw/bank_read_ctrl.sv
hw/wide_buffer_top.sv
sim/wide_buffer_tb.sv

// ==== hw/bank_read_ctrl.sv ====
module bank_read_ctrl #(
   parameter int SLICES = 4                           // slices per word
) (
   input  logic                                  WCLK,
   input  logic                                  rst_n,
   input  logic                                  word_written, // from write side
   input  logic                                  out_credit,   // downstream grant
   sram_bank_if.reader                           bank,
   output logic                                  out_valid,
   output logic [SLICES*sram_geom_pkg::SLICE_W-1:0] out_data,
   output logic                                  in_credit     // slot freed upstream
);

   localparam int SW = sram_geom_pkg::SLICE_W;        // lane width shorthand
   localparam int CW = stream_credit_pkg::CREDIT_W;   // counter width

   // ------------------------------------------------------------
   // counters and read pointer
   // ------------------------------------------------------------

   logic [CW-1:0]                    fill_cnt;        // words stored in RAM
   logic [CW-1:0]                    dn_credits;      // downstream slots held
   logic [sram_geom_pkg::ADDR_W-1:0] rptr;            // next slot to read
   logic                             issue;           // read this cycle
   logic                             rd_pend;         // data lands next cycle

   // need something to read and somewhere to send it
   assign issue = (fill_cnt != '0) && (dn_credits != '0);

   always_ff @(posedge WCLK) begin
      if (!rst_n) begin
         fill_cnt   <= '0;
         dn_credits <= stream_credit_pkg::DOWNSTREAM_CREDITS;
         rptr       <= '0;
         rd_pend    <= 1'b0;
      end else begin
         // both may move in one cycle, net effect applied
         fill_cnt   <= fill_cnt + CW'(word_written) - CW'(issue);
         dn_credits <= dn_credits + CW'(out_credit) - CW'(issue);
         if (issue) begin
            rptr <= rptr + 1'b1;                      // wraps 255 -> 0
         end
         rd_pend    <= issue;                         // one-bit valid pipe
      end
   end

   // ------------------------------------------------------------
   // bank read port
   // ------------------------------------------------------------

   assign bank.ce    = issue;
   assign bank.raddr = rptr;

   // ------------------------------------------------------------
   // output side
   // ------------------------------------------------------------

   // join lanes in write order, slice 0 in the low bits
   always_comb begin
      for (int i = 0; i < SLICES; i++) begin
         out_data[i*SW +: SW] = bank.rdata[i];
      end
   end

   assign out_valid = rd_pend;                        // slice regs loaded last edge
   assign in_credit = rd_pend;                        // word has left the RAM

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // upstream must never send past its credit budget
   a_fill_bound : assert property (
      @(posedge WCLK) disable iff (!rst_n)
      fill_cnt <= stream_credit_pkg::UPSTREAM_CREDITS
   ) else $error("fill count %0d above upstream credits", fill_cnt);

   // each output word took one credit off the count, never below zero
   a_valid_spent : assert property (
      @(posedge WCLK) disable iff (!rst_n)
      out_valid |->
         int'(dn_credits) == int'($past(dn_credits)) + int'($past(out_credit)) - 1
   ) else $error("out_valid without a downstream credit");

endmodule

// ==== hw/bank_write_ctrl.sv ====
module bank_write_ctrl #(
   parameter int SLICES = 4                           // slices per word
) (
   input  logic                                  WCLK,
   input  logic                                  rst_n,
   input  logic                                  in_valid,   // one word per pulse
   input  logic [SLICES*sram_geom_pkg::SLICE_W-1:0] in_data,
   sram_bank_if.writer                           bank,
   output logic                                  word_written // pulse after RAM write
);

   localparam int SW = sram_geom_pkg::SLICE_W;        // lane width shorthand

   // ------------------------------------------------------------
   // control state
   // ------------------------------------------------------------

   logic                             we_q;            // write pending this cycle
   logic [sram_geom_pkg::ADDR_W-1:0] wptr;            // next slot to fill
   logic                             written_q;       // write done last edge

   always_ff @(posedge WCLK) begin
      if (!rst_n) begin
         we_q      <= 1'b0;
         wptr      <= '0;
         written_q <= 1'b0;
      end else begin
         we_q      <= in_valid;                       // register the accept
         written_q <= we_q;                           // RAM wrote at this edge
         if (we_q) begin
            wptr <= wptr + 1'b1;                      // wraps 255 -> 0
         end
      end
   end

   // ------------------------------------------------------------
   // payload split, slice 0 takes the low bits
   // ------------------------------------------------------------

   sram_geom_pkg::slice_word_t wdata_q [SLICES];      // registered lanes

   always_ff @(posedge WCLK) begin
      if (in_valid) begin
         for (int i = 0; i < SLICES; i++) begin
            wdata_q[i] <= in_data[i*SW +: SW];
         end
      end
   end

   // ------------------------------------------------------------
   // bank write port
   // ------------------------------------------------------------

   assign bank.we    = we_q;
   assign bank.waddr = wptr;                          // pointer is the address

   always_comb begin
      for (int i = 0; i < SLICES; i++) begin
         bank.wdata[i] = wdata_q[i];
      end
   end

   assign word_written = written_q;                   // read side may count it now

endmodule

// ==== hw/sram_bank_if.sv ====
interface sram_bank_if #(
   parameter int SLICES = 4                           // slices side by side
);

   // write port, shared by every slice
   logic                         we;                  // write enable
   logic [sram_geom_pkg::ADDR_W-1:0] waddr;           // shared write address
   sram_geom_pkg::slice_word_t   wdata [SLICES];      // one word per slice

   // read port, shared address, one output per slice
   logic                         ce;                  // read enable
   logic [sram_geom_pkg::ADDR_W-1:0] raddr;           // shared read address
   sram_geom_pkg::slice_word_t   rdata [SLICES];      // element i from slice i

   modport writer (
      output we,
      output waddr,
      output wdata
   );

   modport reader (
      output ce,
      output raddr,
      input  rdata
   );

   modport slice (
      input  we,
      input  waddr,
      input  wdata,
      input  ce,
      input  raddr,
      output rdata
   );

endinterface

// ==== hw/sram_geom_pkg.sv ====
package sram_geom_pkg;

   // ------------------------------------------------------------
   // block-RAM slice geometry
   // ------------------------------------------------------------

   // one slice is a 256 x 36 simple-dual-port block RAM
   localparam int SLICE_W = 36;            // data bits per slice word
   localparam int ADDR_W  = 8;             // slice address bits
   localparam int DEPTH   = 1 << ADDR_W;   // 256 entries per slice

   // the payload that one slice stores per address
   // (32 data bits plus 4 parity bits on the primitive)
   typedef logic [SLICE_W-1:0] slice_word_t;

endpackage

// ==== hw/sram_slice.sv ====
module sram_slice #(
   parameter int INDEX = 0                            // position in the bank
) (
   input logic        WCLK,                           // write and read clock
   sram_bank_if.slice bank
);

   // ------------------------------------------------------------
   // storage and registered read port
   // ------------------------------------------------------------

   sram_geom_pkg::slice_word_t mem [sram_geom_pkg::DEPTH];   // 256 x 36 array
   sram_geom_pkg::slice_word_t rd_q;                         // read output reg

   always_ff @(posedge WCLK) begin
      if (bank.we) begin
         mem[bank.waddr] <= bank.wdata[INDEX];        // own lane only
      end
      if (bank.ce) begin
         rd_q <= mem[bank.raddr];                     // holds when ce low
      end
   end

   assign bank.rdata[INDEX] = rd_q;                   // drives one element only

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // the controllers must hand over clean addresses on every access
   a_waddr_known : assert property (
      @(posedge WCLK) bank.we |-> !$isunknown(bank.waddr)
   ) else $error("slice %0d: unknown write address", INDEX);

   a_raddr_known : assert property (
      @(posedge WCLK) bank.ce |-> !$isunknown(bank.raddr)
   ) else $error("slice %0d: unknown read address", INDEX);

endmodule

// ==== hw/stream_credit_pkg.sv ====
package stream_credit_pkg;

   // ------------------------------------------------------------
   // credit counters of the two flow-control links
   // ------------------------------------------------------------

   // 9 bits so a full count of 256 fits
   localparam int CREDIT_W = 9;

   // upstream owns one credit per free word slot after reset
   localparam logic [CREDIT_W-1:0] UPSTREAM_CREDITS =
      CREDIT_W'(sram_geom_pkg::DEPTH);

   // downstream grants everything by pulses, nothing held at reset
   localparam logic [CREDIT_W-1:0] DOWNSTREAM_CREDITS = '0;

endpackage

// ==== hw/wide_buffer_top.sv ====
module wide_buffer_top #(
   parameter int SLICES = 4                           // 4 x 36 = 144-bit word
) (
   input  logic                                  WCLK,
   input  logic                                  rst_n,
   input  logic                                  in_valid,
   input  logic [SLICES*sram_geom_pkg::SLICE_W-1:0] in_data,
   input  logic                                  out_credit,
   output logic                                  out_valid,
   output logic [SLICES*sram_geom_pkg::SLICE_W-1:0] out_data,
   output logic                                  in_credit
);

   // ------------------------------------------------------------
   // shared bank port and write-to-read handoff
   // ------------------------------------------------------------

   sram_bank_if #(.SLICES(SLICES)) bank ();           // one bus for all slices

   logic word_written;                                // write side -> read side

   // ------------------------------------------------------------
   // controllers
   // ------------------------------------------------------------

   bank_write_ctrl #(.SLICES(SLICES)) bank_write_ctrl_inst (
      .WCLK         (WCLK),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .bank         (bank.writer),
      .word_written (word_written)
   );

   bank_read_ctrl #(.SLICES(SLICES)) bank_read_ctrl_inst (
      .WCLK         (WCLK),
      .rst_n        (rst_n),
      .word_written (word_written),
      .out_credit   (out_credit),
      .bank         (bank.reader),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .in_credit    (in_credit)
   );

   // ------------------------------------------------------------
   // RAM slices, side by side
   // ------------------------------------------------------------

   for (genvar i = 0; i < SLICES; i++) begin : g_slice
      sram_slice #(.INDEX(i)) sram_slice_inst (
         .WCLK (WCLK),                                // also the read clock
         .bank (bank.slice)
      );
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the wide buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module wide_buffer_tb \
   -Mdir obj_dir -o wide_buffer_sim \
   -f all.f
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit $status
fi

./obj_dir/wide_buffer_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

// ==== sim/wide_buffer_tb.sv ====
module wide_buffer_tb;

   localparam int SLICES     = 4;                           // 144-bit word
   localparam int SW         = 36;                          // bits per slice lane
   localparam int W          = SLICES * SW;
   localparam int UP_CREDITS = 256;                         // one per RAM slot
   localparam int DRAIN_MAX  = 4000;                        // cycles allowed to drain

   typedef logic [W-1:0] word_t;
   typedef word_t word_q_t[$];

   logic  WCLK;
   logic  rst_n;
   logic  in_valid;
   word_t in_data;
   logic  out_credit;
   logic  out_valid;
   word_t out_data;
   logic  in_credit;

   word_q_t sent_q;                                         // words in flight, oldest first
   string   cur_test      = "reset";
   int      up_credits    = UP_CREDITS;                     // upstream sender's budget
   int      sent_cnt      = 0;
   int      grant_cnt     = 0;                              // out_credit pulses driven
   int      out_valid_cnt = 0;
   int      in_credit_cnt = 0;

   wide_buffer_top #(.SLICES(SLICES)) wide_buffer_top_inst (
      .WCLK       (WCLK),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .in_credit  (in_credit)
   );

   initial begin
      WCLK = 1'b0;
      forever #5 WCLK = ~WCLK;                              // period 10
   end

   // ------------------------------------------------------------
   // failure reporting
   // ------------------------------------------------------------

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_mismatch(input string test, input word_t exp, input word_t act);
      abort_run($sformatf("** Error [%s] expected %0h actual %0h", test, exp, act));
   endtask

   // ------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------

   // random lanes, slice 0 in the low bits
   function automatic word_t make_word();
      word_t       w;
      logic [31:0] lo;
      logic [31:0] hi;
      w = '0;
      for (int i = 0; i < SLICES; i++) begin
         lo = $urandom;
         hi = $urandom;
         w[i*SW +: SW] = {hi[3:0], lo};                     // 36 bits per lane
      end
      return w;
   endfunction

   function automatic bit chance(input int pct);
      return ($urandom % 100) < pct;
   endfunction

   // buffer is FIFO, so the oldest word sent comes out next
   function automatic word_t expected_out(input word_q_t q);
      return q[0];
   endfunction

   // one clock of the upstream and downstream models
   task automatic step_cycle(input bit want_send, input bit want_grant);
      word_t w;
      @(posedge WCLK);
      #1;
      if (in_credit === 1'b1) begin
         up_credits++;                                      // slot freed
      end
      if (want_send && up_credits > 0) begin
         w = make_word();
         in_valid = 1'b1;
         in_data  = w;
         sent_q.push_back(w);
         up_credits--;                                      // one credit per word
         sent_cnt++;
      end else begin
         in_valid = 1'b0;
         in_data  = '0;
      end
      out_credit = want_grant;
      if (want_grant) begin
         grant_cnt++;
      end
   endtask

   // grant whatever is missing and wait for every word to come out
   task automatic drain_all();
      int guard;
      guard = 0;
      while (out_valid_cnt < sent_cnt) begin
         step_cycle(1'b0, grant_cnt < sent_cnt);
         guard++;
         if (guard > DRAIN_MAX) begin
            abort_run($sformatf("timeout in %s: buffer did not drain", cur_test));
         end
      end
      repeat (3) step_cycle(1'b0, 1'b0);                    // let last in_credit land
      assert (up_credits == UP_CREDITS)
         else report_mismatch(cur_test, word_t'(UP_CREDITS), word_t'(up_credits));
   endtask

   task automatic run_traffic(input int n_words, input int send_pct, input int grant_pct);
      int target;
      int guard;
      target = sent_cnt + n_words;
      guard  = 0;
      while (sent_cnt < target) begin
         step_cycle(chance(send_pct), (grant_cnt < target) && chance(grant_pct));
         guard++;
         if (guard > 50 * n_words + 1000) begin
            abort_run($sformatf("timeout in %s: upstream could not send", cur_test));
         end
      end
      drain_all();
   endtask

   // ------------------------------------------------------------
   // checking process, samples at the falling edge
   // ------------------------------------------------------------

   initial begin
      word_t exp;
      forever begin
         @(negedge WCLK);
         if (!rst_n) begin
            assert (out_valid === 1'b0 && in_credit === 1'b0)
               else abort_run("out_valid or in_credit high during reset");
         end else begin
            assert (!$isunknown(out_valid) && !$isunknown(in_credit))
               else abort_run("out_valid or in_credit unknown after reset");
            if (in_credit === 1'b1) begin
               in_credit_cnt++;
            end
            if (out_valid === 1'b1) begin
               out_valid_cnt++;
               assert (sent_q.size() > 0)
                  else abort_run($sformatf("%s: out_valid with no word sent", cur_test));
               exp = expected_out(sent_q);
               void'(sent_q.pop_front());
               assert (out_data === exp)
                  else report_mismatch(cur_test, exp, out_data);
               assert (out_valid_cnt <= grant_cnt)       // never more than granted
                  else abort_run($sformatf("%s: out_valid without a granted credit",
                                           cur_test));
            end
         end
      end
   end

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------

   initial begin
      int bp_out;
      int bp_sent;
      int guard;
      void'($urandom(32'hed92));                            // one seed for the run
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_credit = 1'b0;
      repeat (2) @(posedge WCLK);
      #1 rst_n = 1'b1;

      repeat (5) step_cycle(1'b0, 1'b0);                    // idle right after reset
      assert (out_valid_cnt == 0 && in_credit_cnt == 0)
         else abort_run("output activity right after reset");

      cur_test = "order";
      run_traffic(40, 100, 100);

      // no grants, upstream fills all 256 slots
      cur_test = "backpressure";
      bp_out   = out_valid_cnt;
      bp_sent  = sent_cnt;
      guard    = 0;
      while (up_credits > 0) begin
         step_cycle(1'b1, 1'b0);
         guard++;
         if (guard > 2 * UP_CREDITS) begin
            abort_run("timeout in backpressure: upstream credits never ran out");
         end
      end
      repeat (20) step_cycle(1'b0, 1'b0);                   // hold, stray in_credit shows here
      assert (sent_cnt - bp_sent == UP_CREDITS)
         else report_mismatch(cur_test, word_t'(UP_CREDITS), word_t'(sent_cnt - bp_sent));
      assert (up_credits == 0)
         else report_mismatch(cur_test, word_t'(0), word_t'(up_credits));
      assert (out_valid_cnt == bp_out)
         else report_mismatch(cur_test, word_t'(bp_out), word_t'(out_valid_cnt));
      drain_all();

      cur_test = "wrap";
      run_traffic(700, 60, 50);                             // pointers wrap several times

      cur_test = "credit_accounting";
      assert (in_credit_cnt == out_valid_cnt)
         else report_mismatch(cur_test, word_t'(out_valid_cnt), word_t'(in_credit_cnt));

      $display("TEST PASSED");
      $finish;
   end

endmodule
